// File: axil_mem.f
+incdir+rtl
rtl/axil_pkg.sv
rtl/mem_pkg.sv
rtl/mem_bank.sv
rtl/axil_write_ctrl.sv
rtl/axil_read_ctrl.sv
rtl/axil_mem_top.sv
test/tb_clock.sv
test/axil_mem_sva.sv
test/axil_mem_checker.sv
test/axil_mem_tb.sv

// File: rtl/axil_mem_consts.svh
// AXI4-Lite bus widths and memory depth constants
`ifndef AXIL_MEM_CONSTS_SVH
`define AXIL_MEM_CONSTS_SVH

// AXI4-Lite channel widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Byte lane bits at the bottom of an address
`define AXIL_LANE_W 2

// Word index carried by one address word
`define AXIL_WIDX_W (`AXIL_ADDR_W - `AXIL_LANE_W)

// Block RAM size in words
`define MEM_DEPTH 1024
`define MEM_IDX_W 10

`endif

// File: rtl/axil_mem_top.sv
// AXI4-Lite slave memory top with write controller, read controller and RAM bank
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_mem_top (
    input  logic                    aclk,
    input  logic                    aresetn,

    input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr,
    input  axil_pkg::prot_t         s_axil_awprot,   // Accepted, not used
    input  logic                    s_axil_awvalid,
    output logic                    s_axil_awready,

    input  logic [`AXIL_DATA_W-1:0] s_axil_wdata,
    input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb,
    input  logic                    s_axil_wvalid,
    output logic                    s_axil_wready,

    output axil_pkg::resp_t         s_axil_bresp,
    output logic                    s_axil_bvalid,
    input  logic                    s_axil_bready,

    input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr,
    input  axil_pkg::prot_t         s_axil_arprot,   // Accepted, not used
    input  logic                    s_axil_arvalid,
    output logic                    s_axil_arready,

    output logic [`AXIL_DATA_W-1:0] s_axil_rdata,
    output axil_pkg::resp_t         s_axil_rresp,
    output logic                    s_axil_rvalid,
    input  logic                    s_axil_rready
);
    // RAM write port
    logic                    wr_en;
    logic [`MEM_IDX_W-1:0]   wr_idx;
    logic [`AXIL_DATA_W-1:0] wr_data;
    logic [`AXIL_STRB_W-1:0] wr_strb;

    // RAM read port
    logic                    rd_en;
    logic [`MEM_IDX_W-1:0]   rd_idx;
    logic [`AXIL_DATA_W-1:0] rd_data;

    axil_write_ctrl u_write_ctrl (
        .aclk    (aclk),           .aresetn (aresetn),
        .awaddr  (s_axil_awaddr),  .awvalid (s_axil_awvalid), .awready (s_axil_awready),
        .wdata   (s_axil_wdata),   .wstrb   (s_axil_wstrb),
        .wvalid  (s_axil_wvalid),  .wready  (s_axil_wready),
        .bresp   (s_axil_bresp),   .bvalid  (s_axil_bvalid),  .bready  (s_axil_bready),
        .wr_en   (wr_en),          .wr_idx  (wr_idx),
        .wr_data (wr_data),        .wr_strb (wr_strb)
    );

    axil_read_ctrl u_read_ctrl (
        .aclk    (aclk),           .aresetn (aresetn),
        .araddr  (s_axil_araddr),  .arvalid (s_axil_arvalid), .arready (s_axil_arready),
        .rdata   (s_axil_rdata),   .rresp   (s_axil_rresp),
        .rvalid  (s_axil_rvalid),  .rready  (s_axil_rready),
        .rd_en   (rd_en),          .rd_idx  (rd_idx),         .rd_data (rd_data)
    );

    mem_bank u_mem_bank (
        .aclk    (aclk),
        .wr_en   (wr_en),          .wr_idx  (wr_idx),
        .wr_data (wr_data),        .wr_strb (wr_strb),
        .rd_en   (rd_en),          .rd_idx  (rd_idx),         .rd_data (rd_data)
    );

endmodule

// File: rtl/axil_pkg.sv
// AXI4-Lite response code and protection types
package axil_pkg;

    // Only the codes this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // Privileged, non-secure and instruction bits
    typedef logic [2:0] prot_t;

endpackage

// File: rtl/axil_read_ctrl.sv
// AXI4-Lite read channel controller with one read slot
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_read_ctrl (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output axil_pkg::resp_t         rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic                    rd_en,
    output logic [`MEM_IDX_W-1:0]   rd_idx,
    input  logic [`AXIL_DATA_W-1:0] rd_data
);
    mem_pkg::addr_word_u ar_word;
    logic                ar_in_range;
    logic                rd_ok;  // Range result of the read in the slot

    assign ar_word.byte_addr = araddr;
    assign rd_idx            = ar_word.fields.idx;

    assign ar_in_range = {ar_word.fields.idx_hi, ar_word.fields.idx}
                         < `AXIL_WIDX_W'(`MEM_DEPTH);

    // Slot empty or draining this cycle
    assign arready = !rvalid || rready;

    // RAM read register loads on the AR handshake edge
    assign rd_en = arvalid && arready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) rd_ok <= ar_in_range;
    end

    // RAM output holds while rd_en is low, so data is stable under back-pressure
    assign rdata = rd_ok ? rd_data : '0;
    assign rresp = rd_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;

endmodule

// File: rtl/axil_write_ctrl.sv
// AXI4-Lite write channel controller with address and data holding registers
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_write_ctrl (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic [`AXIL_STRB_W-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output axil_pkg::resp_t         bresp,
    output logic                    bvalid,
    input  logic                    bready,
    output logic                    wr_en,
    output logic [`MEM_IDX_W-1:0]   wr_idx,
    output logic [`AXIL_DATA_W-1:0] wr_data,
    output logic [`AXIL_STRB_W-1:0] wr_strb
);
    mem_pkg::addr_word_u aw_word;  // Held write address
    logic                aw_full;
    logic                w_full;
    logic                commit;   // RAM write cycle of a joined pair
    logic                join_req;
    logic                aw_in_range;

    assign awready = !aw_full;
    assign wready  = !w_full;
    assign wr_idx  = aw_word.fields.idx;

    // Whole word index against the bank size
    assign aw_in_range = {aw_word.fields.idx_hi, aw_word.fields.idx}
                         < `AXIL_WIDX_W'(`MEM_DEPTH);

    // Both halves present, nothing in flight, B slot empty
    assign join_req = aw_full && w_full && !commit && !bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
        end else begin
            if (awvalid && awready) aw_full <= 1'b1;
            else if (commit)        aw_full <= 1'b0;
            if (wvalid && wready)   w_full  <= 1'b1;
            else if (commit)        w_full  <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (awvalid && awready) aw_word.byte_addr <= awaddr;
        if (wvalid && wready) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (commit) bresp <= aw_in_range ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            commit <= 1'b0;
            wr_en  <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            commit <= join_req;
            wr_en  <= join_req && aw_in_range;  // Out-of-range writes leave the RAM alone
            if (commit)      bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

endmodule

// File: rtl/mem_bank.sv
// Block RAM bank with byte-enabled write port and registered read port
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module mem_bank (
    input  logic                    aclk,
    input  logic                    wr_en,
    input  logic [`MEM_IDX_W-1:0]   wr_idx,
    input  logic [`AXIL_DATA_W-1:0] wr_data,
    input  logic [`AXIL_STRB_W-1:0] wr_strb,
    input  logic                    rd_en,
    input  logic [`MEM_IDX_W-1:0]   rd_idx,
    output logic [`AXIL_DATA_W-1:0] rd_data
);
    logic [`AXIL_DATA_W-1:0] mem [`MEM_DEPTH];

    // One enable per byte lane
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int lane = 0; lane < `AXIL_STRB_W; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_idx][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    // Output register holds between reads
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// File: rtl/mem_pkg.sv
// Address word decode types for the memory bank
`include "axil_mem_consts.svh"

package mem_pkg;

    // Word index split at the bank size and followed by the byte lane
    typedef struct packed {
        logic [`AXIL_WIDX_W-`MEM_IDX_W-1:0] idx_hi;  // Nonzero means out of range
        logic [`MEM_IDX_W-1:0]              idx;     // Bank word
        logic [`AXIL_LANE_W-1:0]            lane;    // Ignored for word access
    } addr_fields_t;

    // One address word seen as bytes or as word and lane
    typedef union packed {
        logic [`AXIL_ADDR_W-1:0] byte_addr;
        addr_fields_t            fields;
    } addr_word_u;

endpackage

// File: test/axil_mem_checker.sv
// Response checker comparing B and R handshakes with stim file expectations
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_mem_checker (
    input logic                    aclk,
    input logic                    aresetn,
    input axil_pkg::resp_t         bresp,
    input logic                    bvalid,
    input logic                    bready,
    input logic [`AXIL_DATA_W-1:0] rdata,
    input axil_pkg::resp_t         rresp,
    input logic                    rvalid,
    input logic                    rready
);
    localparam int          MAX_TESTS = 32;
    localparam int          FIELDS    = 6;
    localparam logic [31:0] OP_WRITE  = 32'd1;
    localparam logic [31:0] OP_READ   = 32'd2;

    logic [31:0] stim_mem [MAX_TESTS*FIELDS];
    int          n_tests;
    int          b_idx;             // Next line waiting for a B response
    int          r_idx;             // Next line waiting for an R response
    int          pass_count   = 0;
    int          fail_count   = 0;
    int          other_errors = 0;  // Extra, missing or absent responses

    function automatic int next_line(input int from, input logic [31:0] op);
        int i;
        i = from;
        while (i < n_tests && stim_mem[i*FIELDS] != op) begin
            i++;
        end
        return i;
    endfunction

    initial begin
        $readmemh("test/axil_mem_stim.hex", stim_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && (stim_mem[n_tests*FIELDS] == OP_WRITE ||
               stim_mem[n_tests*FIELDS] == OP_READ)) begin
            n_tests++;
        end
        b_idx = next_line(0, OP_WRITE);
        r_idx = next_line(0, OP_READ);
    end

    task automatic check_write_resp();
        logic [1:0] exp_resp;
        if (b_idx >= n_tests) begin
            other_errors++;
            $display("Unexpected B response with no write left to match it");
        end else begin
            exp_resp = stim_mem[b_idx*FIELDS+5][1:0];
            if (bresp !== exp_resp) begin
                fail_count++;
                $display("CHECK FAILED test %0d s_axil_bresp: got 0x%h expected 0x%h",
                         b_idx + 1, bresp, exp_resp);
            end else begin
                pass_count++;
                $display("test %0d write 0x%h ok, bresp 0x%h",
                         b_idx + 1, stim_mem[b_idx*FIELDS+1], bresp);
            end
            b_idx = next_line(b_idx + 1, OP_WRITE);
        end
    endtask

    task automatic check_read_resp();
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        if (r_idx >= n_tests) begin
            other_errors++;
            $display("Unexpected R response with no read left to match it");
        end else begin
            exp_data = stim_mem[r_idx*FIELDS+4];
            exp_resp = stim_mem[r_idx*FIELDS+5][1:0];
            if (rdata !== exp_data)
                $display("CHECK FAILED test %0d s_axil_rdata: got 0x%h expected 0x%h",
                         r_idx + 1, rdata, exp_data);
            if (rresp !== exp_resp)
                $display("CHECK FAILED test %0d s_axil_rresp: got 0x%h expected 0x%h",
                         r_idx + 1, rresp, exp_resp);
            if (rdata !== exp_data || rresp !== exp_resp) begin
                fail_count++;
            end else begin
                pass_count++;
                $display("test %0d read 0x%h ok, rdata 0x%h rresp 0x%h",
                         r_idx + 1, stim_mem[r_idx*FIELDS+1], rdata, rresp);
            end
            r_idx = next_line(r_idx + 1, OP_READ);
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn && bvalid && bready) check_write_resp();
        if (aresetn && rvalid && rready) check_read_resp();
    end

    // Prints the closing counts and returns the number of problems seen
    function automatic int summarize(input int assert_fails);
        if (n_tests == 0) begin
            other_errors++;
            $display("The stim file holds no tests");
        end
        if (b_idx < n_tests) begin
            other_errors++;
            $display("No B response arrived for test %0d", b_idx + 1);
        end
        if (r_idx < n_tests) begin
            other_errors++;
            $display("No R response arrived for test %0d", r_idx + 1);
        end
        $display("Summary: %0d passed, %0d failed, %0d other errors, %0d assertion failures",
                 pass_count, fail_count, other_errors, assert_fails);
        return fail_count + other_errors + assert_fails;
    endfunction

endmodule

// File: test/axil_mem_stim.hex
// Columns: op (1 write, 2 read), address, write data, strobe, expected read data,
// expected response (0 OKAY, 2 SLVERR). A line with op 0 ends the list.
1 00000010 11223344 F 00000000 0
2 00000010 00000000 0 11223344 0
1 00000020 A5A5A5A5 F 00000000 0
1 00000020 0000BE00 2 00000000 0
2 00000020 00000000 0 A5A5BEA5 0
1 00000023 77000000 8 00000000 0
2 00000021 00000000 0 77A5BEA5 0
1 00000FFC CAFEF00D F 00000000 0
2 00000FFC 00000000 0 CAFEF00D 0
1 00001010 DEADBEEF F 00000000 2
2 00001010 00000000 0 00000000 2
2 00000010 00000000 0 11223344 0
1 80000020 FFFFFFFF F 00000000 2
2 00000020 00000000 0 77A5BEA5 0
1 00001000 12345678 F 00000000 2
2 00001000 00000000 0 00000000 2
1 00000010 AA0000BB 9 00000000 0
2 00000012 00000000 0 AA2233BB 0
0 00000000 00000000 0 00000000 0

// File: test/axil_mem_sva.sv
// Bound assertions on response channel stability, reset state and read ordering
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_mem_sva (
    input logic                    aclk,
    input logic                    aresetn,
    input axil_pkg::resp_t         s_axil_bresp,
    input logic                    s_axil_bvalid,
    input logic                    s_axil_bready,
    input logic                    s_axil_arvalid,
    input logic                    s_axil_arready,
    input logic [`AXIL_DATA_W-1:0] s_axil_rdata,
    input axil_pkg::resp_t         s_axil_rresp,
    input logic                    s_axil_rvalid,
    input logic                    s_axil_rready
);
    int assert_fails = 0;  // Failed assertion count

    // Held responses keep valid and payload
    b_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
        else begin
            assert_fails++;
            $error("B channel dropped or changed while bready was low");
        end

    r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready
        |=> s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
        else begin
            assert_fails++;
            $error("R channel dropped or changed while rready was low");
        end

    reset_idle: assert property (@(posedge aclk)
        !aresetn |=> !s_axil_bvalid && !s_axil_rvalid)
        else begin
            assert_fails++;
            $error("Response valid high after a reset cycle");
        end

    // A new read beat needs an AR handshake on the edge before
    r_after_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !$past(s_axil_rvalid && !s_axil_rready)
        |-> $past(s_axil_arvalid && s_axil_arready))
        else begin
            assert_fails++;
            $error("Read data appeared without an AR handshake");
        end

endmodule

// File: test/axil_mem_tb.sv
// Testbench top for the AXI4-Lite memory with stimulus driver, back-pressure and watchdog
`timescale 1ns/1ps
`include "axil_mem_consts.svh"

module axil_mem_tb;
    localparam int          MAX_TESTS       = 32;
    localparam int          FIELDS          = 6;   // Words per stim line
    localparam int          RESET_CYCLES    = 16;
    localparam int          CYCLES_PER_TEST = 50;
    localparam logic [31:0] OP_WRITE        = 32'd1;
    localparam logic [31:0] OP_READ         = 32'd2;

    logic                    aclk;
    logic                    aresetn;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    axil_pkg::resp_t         bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    axil_pkg::resp_t         rresp;
    logic                    rvalid;
    logic                    rready;

    logic [31:0] stim_mem [MAX_TESTS*FIELDS];
    int          n_tests;
    bit          load_done;
    integer      seed = 32'he38d_435c;
    int          total_errors;

    tb_clock u_clock (.aclk(aclk));

    axil_mem_top u_dut (
        .aclk           (aclk),     .aresetn        (aresetn),
        .s_axil_awaddr  (awaddr),   .s_axil_awprot  (3'b000),
        .s_axil_awvalid (awvalid),  .s_axil_awready (awready),
        .s_axil_wdata   (wdata),    .s_axil_wstrb   (wstrb),
        .s_axil_wvalid  (wvalid),   .s_axil_wready  (wready),
        .s_axil_bresp   (bresp),    .s_axil_bvalid  (bvalid),   .s_axil_bready  (bready),
        .s_axil_araddr  (araddr),   .s_axil_arprot  (3'b000),
        .s_axil_arvalid (arvalid),  .s_axil_arready (arready),
        .s_axil_rdata   (rdata),    .s_axil_rresp   (rresp),
        .s_axil_rvalid  (rvalid),   .s_axil_rready  (rready)
    );

    axil_mem_checker u_checker (
        .aclk   (aclk),   .aresetn (aresetn),
        .bresp  (bresp),  .bvalid  (bvalid),  .bready (bready),
        .rdata  (rdata),  .rresp   (rresp),   .rvalid (rvalid),  .rready (rready)
    );

    bind axil_mem_top axil_mem_sva u_sva (.*);

    // Master accepts responses about three cycles in four
    always @(posedge aclk) begin : back_pressure
        logic [31:0] rnd;
        rnd = $random(seed);
        bready <= |rnd[1:0];
        rready <= |rnd[3:2];
    end

    task automatic drive_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        bit b_done;
        b_done = 1'b0;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        while (!b_done) begin
            @(posedge aclk);
            if (awvalid && awready) awvalid <= 1'b0;
            if (wvalid && wready)   wvalid  <= 1'b0;
            b_done = bvalid && bready;  // Response taken so the next request may start
        end
    endtask

    task automatic drive_read(input logic [31:0] addr);
        bit r_done;
        r_done = 1'b0;
        araddr  <= addr;
        arvalid <= 1'b1;
        while (!r_done) begin
            @(posedge aclk);
            if (arvalid && arready) arvalid <= 1'b0;
            r_done = rvalid && rready;
        end
    endtask

    initial begin
        aresetn <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        $readmemh("test/axil_mem_stim.hex", stim_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && (stim_mem[n_tests*FIELDS] == OP_WRITE ||
               stim_mem[n_tests*FIELDS] == OP_READ)) begin
            n_tests++;
        end
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        for (int i = 0; i < n_tests; i++) begin
            if (stim_mem[i*FIELDS] == OP_WRITE)
                drive_write(stim_mem[i*FIELDS+1], stim_mem[i*FIELDS+2],
                            stim_mem[i*FIELDS+3][3:0]);
            else
                drive_read(stim_mem[i*FIELDS+1]);
        end
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        total_errors = u_checker.summarize(u_dut.u_sva.assert_fails);
        if (total_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        wait (load_done);
        repeat (RESET_CYCLES + n_tests * CYCLES_PER_TEST) @(posedge aclk);
        $display("Watchdog expired after %0d cycles with responses still pending",
                 RESET_CYCLES + n_tests * CYCLES_PER_TEST);
        $display("tests failed");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
// Free-running testbench clock with an 8 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic aclk
);
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;  // Half period
    end

endmodule
